// ==== aqed_params.svh ====
`ifndef AQED_PARAMS_SVH
`define AQED_PARAMS_SVH

// number of queue element slots in the shared list
`define AQED_DEPTH 2048

// slot address width, log2 of the slot count
`define AQED_AW 11

// queue element payload width
`define AQED_DW 139

// stored pointer word in the freelist and next-pointer srams
// upper bits above the slot address are written as zero
`define AQED_PW 16

`endif

// ==== aqed_pkg.sv ====
`include "aqed_params.svh"

package aqed_pkg;

// slot number that indexes all three srams
typedef logic [`AQED_AW-1:0] slot_t;

// pointer word as stored in the freelist and next-pointer srams
typedef logic [`AQED_PW-1:0] ptr_t;

// one queue element
typedef logic [`AQED_DW-1:0] qe_t;

// occupancy is one bit wider than a slot so a full list fits
typedef logic [`AQED_AW:0] count_t;

typedef enum logic [1:0] {
    fl_st_init,
    fl_st_idle,
    fl_st_pop_rd,
    fl_st_push
} fl_state_t;

typedef enum logic [1:0] {
    ls_idle,
    ls_enq_wr,
    ls_deq_rd
} list_state_t;

endpackage

// ==== aqed_sram_pg.sv ====
`timescale 1ns/1ps

module aqed_sram_pg #(
     parameter int depth = 2048
    ,parameter int width = 16
) (
     input  logic                         clk
    ,input  logic                         arst_n
    ,input  logic                         we
    ,input  logic                         re
    ,input  logic [$clog2(depth)-1:0]     addr
    ,input  logic [width-1:0]             wdata
    ,output logic [width-1:0]             rdata

    ,input  logic                         pwr_enable_b_in
    ,output logic                         pwr_enable_b_out
);

logic [width-1:0] mem [depth];

// rdata keeps the last read word between reads
always_ff @(posedge clk) begin
    if (we) begin
        mem[addr] <= wdata;
    end
    if (re) begin
        rdata <= mem[addr];
    end
end

// one power switch acknowledge flop per macro
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        pwr_enable_b_out <= 1'b1;
    end else begin
        pwr_enable_b_out <= pwr_enable_b_in;
    end
end

endmodule

// ==== aqed_mem.sv ====
`timescale 1ns/1ps

`include "aqed_params.svh"

module aqed_mem (
     input  logic                  clk
    ,input  logic                  arst_n

    ,input  aqed_pkg::slot_t       data_addr
    ,input  logic                  data_we
    ,input  aqed_pkg::qe_t         data_wdata
    ,input  logic                  data_re
    ,output aqed_pkg::qe_t         data_rdata

    ,input  aqed_pkg::slot_t       fl_addr
    ,input  logic                  fl_we
    ,input  aqed_pkg::ptr_t        fl_wdata
    ,input  logic                  fl_re
    ,output aqed_pkg::ptr_t        fl_rdata

    ,input  aqed_pkg::slot_t       nxt_addr
    ,input  logic                  nxt_we
    ,input  aqed_pkg::ptr_t        nxt_wdata
    ,input  logic                  nxt_re
    ,output aqed_pkg::ptr_t        nxt_rdata

    ,input  logic                  pwr_enable_b_in
    ,output logic                  pwr_enable_b_out
);

// power enable ripples data -> freelist -> next pointer
logic pwr_data_to_fl;
logic pwr_fl_to_nxt;

aqed_sram_pg #(
     .depth                   (`AQED_DEPTH)
    ,.width                   (`AQED_DW)
) i_sr_aqed (
     .clk                     (clk)
    ,.arst_n                  (arst_n)
    ,.we                      (data_we)
    ,.re                      (data_re)
    ,.addr                    (data_addr)
    ,.wdata                   (data_wdata)
    ,.rdata                   (data_rdata)
    ,.pwr_enable_b_in         (pwr_enable_b_in)
    ,.pwr_enable_b_out        (pwr_data_to_fl)
);

aqed_sram_pg #(
     .depth                   (`AQED_DEPTH)
    ,.width                   (`AQED_PW)
) i_sr_aqed_freelist (
     .clk                     (clk)
    ,.arst_n                  (arst_n)
    ,.we                      (fl_we)
    ,.re                      (fl_re)
    ,.addr                    (fl_addr)
    ,.wdata                   (fl_wdata)
    ,.rdata                   (fl_rdata)
    ,.pwr_enable_b_in         (pwr_data_to_fl)
    ,.pwr_enable_b_out        (pwr_fl_to_nxt)
);

aqed_sram_pg #(
     .depth                   (`AQED_DEPTH)
    ,.width                   (`AQED_PW)
) i_sr_aqed_ll_qe_hpnxt (
     .clk                     (clk)
    ,.arst_n                  (arst_n)
    ,.we                      (nxt_we)
    ,.re                      (nxt_re)
    ,.addr                    (nxt_addr)
    ,.wdata                   (nxt_wdata)
    ,.rdata                   (nxt_rdata)
    ,.pwr_enable_b_in         (pwr_fl_to_nxt)
    ,.pwr_enable_b_out        (pwr_enable_b_out)
);

endmodule

// ==== aqed_freelist_ctl.sv ====
`timescale 1ns/1ps

`include "aqed_params.svh"

module aqed_freelist_ctl (
     input  logic                  clk
    ,input  logic                  arst_n

    ,input  logic                  pop
    ,output aqed_pkg::slot_t       slot
    ,output logic                  slot_valid
    ,input  logic                  push
    ,input  aqed_pkg::slot_t       push_slot
    ,output logic                  init_done

    ,output aqed_pkg::slot_t       fl_addr
    ,output logic                  fl_we
    ,output aqed_pkg::ptr_t        fl_wdata
    ,output logic                  fl_re
    ,input  aqed_pkg::ptr_t        fl_rdata
);

aqed_pkg::fl_state_t state;
aqed_pkg::slot_t     init_cnt;
aqed_pkg::slot_t     rd_idx;
aqed_pkg::slot_t     wr_idx;
aqed_pkg::slot_t     push_q;

// ring indices wrap on their own since the depth is a power of two
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state    <= aqed_pkg::fl_st_init;
        init_cnt <= '0;
        rd_idx   <= '0;
        wr_idx   <= '0;
    end else begin
        case (state)
            aqed_pkg::fl_st_init: begin
                init_cnt <= init_cnt + 1'b1;
                if (init_cnt == aqed_pkg::slot_t'(`AQED_DEPTH - 1)) begin
                    state <= aqed_pkg::fl_st_idle;
                end
            end
            aqed_pkg::fl_st_idle: begin
                if (pop) begin
                    rd_idx <= rd_idx + 1'b1;
                    state  <= aqed_pkg::fl_st_pop_rd;
                end else if (push) begin
                    state <= aqed_pkg::fl_st_push;
                end
            end
            aqed_pkg::fl_st_pop_rd: begin
                state <= aqed_pkg::fl_st_idle;
            end
            aqed_pkg::fl_st_push: begin
                wr_idx <= wr_idx + 1'b1;
                state  <= aqed_pkg::fl_st_idle;
            end
            default: begin
                state <= aqed_pkg::fl_st_idle;
            end
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == aqed_pkg::fl_st_idle && push) begin
        push_q <= push_slot;
    end
end

// init fill has the sram port to itself
always_comb begin
    fl_we    = 1'b0;
    fl_re    = 1'b0;
    fl_addr  = rd_idx;
    fl_wdata = aqed_pkg::ptr_t'(push_q);
    case (state)
        aqed_pkg::fl_st_init: begin
            fl_we    = 1'b1;
            fl_addr  = init_cnt;
            fl_wdata = aqed_pkg::ptr_t'(init_cnt);
        end
        aqed_pkg::fl_st_idle: begin
            fl_re = pop;
        end
        aqed_pkg::fl_st_push: begin
            fl_we   = 1'b1;
            fl_addr = wr_idx;
        end
        default: begin
        end
    endcase
end

assign slot       = aqed_pkg::slot_t'(fl_rdata);
assign slot_valid = (state == aqed_pkg::fl_st_pop_rd);
assign init_done  = (state != aqed_pkg::fl_st_init);

endmodule

// ==== aqed_list_ctl.sv ====
`timescale 1ns/1ps

`include "aqed_params.svh"

module aqed_list_ctl (
     input  logic                  clk
    ,input  logic                  arst_n

    ,input  logic                  enq
    ,input  aqed_pkg::qe_t         enq_qe
    ,input  logic                  deq
    ,output logic                  ready
    ,output logic                  deq_valid
    ,output aqed_pkg::qe_t         deq_qe
    ,output aqed_pkg::count_t      occupancy
    ,output logic [7:0]            err_count

    ,input  logic                  init_done
    ,output logic                  fl_pop
    ,input  aqed_pkg::slot_t       fl_slot
    ,input  logic                  fl_slot_valid
    ,output logic                  fl_push
    ,output aqed_pkg::slot_t       fl_push_slot

    ,output aqed_pkg::slot_t       data_addr
    ,output logic                  data_we
    ,output aqed_pkg::qe_t         data_wdata
    ,output logic                  data_re
    ,input  aqed_pkg::qe_t         data_rdata

    ,output aqed_pkg::slot_t       nxt_addr
    ,output logic                  nxt_we
    ,output aqed_pkg::ptr_t        nxt_wdata
    ,output logic                  nxt_re
    ,input  aqed_pkg::ptr_t        nxt_rdata
);

aqed_pkg::list_state_t state;
aqed_pkg::slot_t       head;
aqed_pkg::slot_t       tail;
aqed_pkg::qe_t         enq_qe_q;

logic accept_enq;
logic accept_deq;
logic drop;
logic enq_done;
logic deq_done;

assign ready = init_done && (state == aqed_pkg::ls_idle);

// both strobes together is never legal
assign accept_enq = ready && enq && !deq &&
                    (occupancy < aqed_pkg::count_t'(`AQED_DEPTH));
assign accept_deq = ready && deq && !enq && (occupancy != '0);
assign drop       = (enq || deq) && !accept_enq && !accept_deq;

// second step of each sequence
assign enq_done = (state == aqed_pkg::ls_enq_wr) && fl_slot_valid;
assign deq_done = (state == aqed_pkg::ls_deq_rd) && deq_valid;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state     <= aqed_pkg::ls_idle;
        head      <= '0;
        tail      <= '0;
        occupancy <= '0;
        err_count <= '0;
        fl_pop    <= 1'b0;
        deq_valid <= 1'b0;
    end else begin
        fl_pop    <= accept_enq;
        deq_valid <= (state == aqed_pkg::ls_deq_rd) && !deq_valid;
        if (drop && err_count != 8'hff) begin
            err_count <= err_count + 1'b1;
        end
        case (state)
            aqed_pkg::ls_idle: begin
                if (accept_enq) begin
                    state <= aqed_pkg::ls_enq_wr;
                end else if (accept_deq) begin
                    state <= aqed_pkg::ls_deq_rd;
                end
            end
            aqed_pkg::ls_enq_wr: begin
                if (fl_slot_valid) begin
                    tail <= fl_slot;
                    // first element becomes the head as well
                    if (occupancy == '0) begin
                        head <= fl_slot;
                    end
                    occupancy <= occupancy + 1'b1;
                    state     <= aqed_pkg::ls_idle;
                end
            end
            aqed_pkg::ls_deq_rd: begin
                if (deq_valid) begin
                    head      <= aqed_pkg::slot_t'(nxt_rdata);
                    occupancy <= occupancy - 1'b1;
                    state     <= aqed_pkg::ls_idle;
                end
            end
            default: begin
                state <= aqed_pkg::ls_idle;
            end
        endcase
    end
end

always_ff @(posedge clk) begin
    if (accept_enq) begin
        enq_qe_q <= enq_qe;
    end
end

// new slot gets the payload, old tail gets linked to it
assign data_we    = enq_done;
assign data_addr  = (state == aqed_pkg::ls_enq_wr) ? fl_slot : head;
assign data_wdata = enq_qe_q;
assign nxt_we     = enq_done && (occupancy != '0);
assign nxt_addr   = (state == aqed_pkg::ls_enq_wr) ? tail : head;
assign nxt_wdata  = aqed_pkg::ptr_t'(fl_slot);

// head payload and link are fetched together
assign data_re = (state == aqed_pkg::ls_deq_rd) && !deq_valid;
assign nxt_re  = data_re;
assign deq_qe  = data_rdata;

assign fl_push      = deq_done;
assign fl_push_slot = head;

endmodule

// ==== aqed_top.sv ====
`timescale 1ns/1ps

module aqed_top (
     input  logic                  clk
    ,input  logic                  arst_n

    ,input  logic                  enq
    ,input  aqed_pkg::qe_t         enq_qe
    ,input  logic                  deq
    ,output logic                  ready
    ,output logic                  deq_valid
    ,output aqed_pkg::qe_t         deq_qe
    ,output aqed_pkg::count_t      occupancy
    ,output logic [7:0]            err_count

    ,input  logic                  pwr_enable_b_in
    ,output logic                  pwr_enable_b_out
);

logic             init_done;
logic             fl_pop;
aqed_pkg::slot_t  fl_slot;
logic             fl_slot_valid;
logic             fl_push;
aqed_pkg::slot_t  fl_push_slot;

aqed_pkg::slot_t  data_addr;
logic             data_we;
aqed_pkg::qe_t    data_wdata;
logic             data_re;
aqed_pkg::qe_t    data_rdata;

aqed_pkg::slot_t  fl_addr;
logic             fl_we;
aqed_pkg::ptr_t   fl_wdata;
logic             fl_re;
aqed_pkg::ptr_t   fl_rdata;

aqed_pkg::slot_t  nxt_addr;
logic             nxt_we;
aqed_pkg::ptr_t   nxt_wdata;
logic             nxt_re;
aqed_pkg::ptr_t   nxt_rdata;

aqed_list_ctl i_list (
     .clk                     (clk)
    ,.arst_n                  (arst_n)
    ,.enq                     (enq)
    ,.enq_qe                  (enq_qe)
    ,.deq                     (deq)
    ,.ready                   (ready)
    ,.deq_valid               (deq_valid)
    ,.deq_qe                  (deq_qe)
    ,.occupancy               (occupancy)
    ,.err_count               (err_count)
    ,.init_done               (init_done)
    ,.fl_pop                  (fl_pop)
    ,.fl_slot                 (fl_slot)
    ,.fl_slot_valid           (fl_slot_valid)
    ,.fl_push                 (fl_push)
    ,.fl_push_slot            (fl_push_slot)
    ,.data_addr               (data_addr)
    ,.data_we                 (data_we)
    ,.data_wdata              (data_wdata)
    ,.data_re                 (data_re)
    ,.data_rdata              (data_rdata)
    ,.nxt_addr                (nxt_addr)
    ,.nxt_we                  (nxt_we)
    ,.nxt_wdata               (nxt_wdata)
    ,.nxt_re                  (nxt_re)
    ,.nxt_rdata               (nxt_rdata)
);

aqed_freelist_ctl i_freelist (
     .clk                     (clk)
    ,.arst_n                  (arst_n)
    ,.pop                     (fl_pop)
    ,.slot                    (fl_slot)
    ,.slot_valid              (fl_slot_valid)
    ,.push                    (fl_push)
    ,.push_slot               (fl_push_slot)
    ,.init_done               (init_done)
    ,.fl_addr                 (fl_addr)
    ,.fl_we                   (fl_we)
    ,.fl_wdata                (fl_wdata)
    ,.fl_re                   (fl_re)
    ,.fl_rdata                (fl_rdata)
);

aqed_mem i_mem (
     .clk                     (clk)
    ,.arst_n                  (arst_n)
    ,.data_addr               (data_addr)
    ,.data_we                 (data_we)
    ,.data_wdata              (data_wdata)
    ,.data_re                 (data_re)
    ,.data_rdata              (data_rdata)
    ,.fl_addr                 (fl_addr)
    ,.fl_we                   (fl_we)
    ,.fl_wdata                (fl_wdata)
    ,.fl_re                   (fl_re)
    ,.fl_rdata                (fl_rdata)
    ,.nxt_addr                (nxt_addr)
    ,.nxt_we                  (nxt_we)
    ,.nxt_wdata               (nxt_wdata)
    ,.nxt_re                  (nxt_re)
    ,.nxt_rdata               (nxt_rdata)
    ,.pwr_enable_b_in         (pwr_enable_b_in)
    ,.pwr_enable_b_out        (pwr_enable_b_out)
);

endmodule

// ==== tb_aqed_top.sv ====
`timescale 1ns/1ps

`include "aqed_params.svh"

module tb_aqed_top;

localparam int n_random    = 3000;
localparam int n_cmds      = n_random + 2 * `AQED_DEPTH + 16;
localparam int cycle_limit = `AQED_DEPTH + 16 + 3 * n_cmds + 200;

logic              clk;
logic              arst_n;
logic              enq;
aqed_pkg::qe_t     enq_qe;
logic              deq;
logic              ready;
logic              deq_valid;
aqed_pkg::qe_t     deq_qe;
aqed_pkg::count_t  occupancy;
logic [7:0]        err_count;
logic              pwr_enable_b_in;
logic              pwr_enable_b_out;

integer            seed;
int                cycles;

// reference queue and expected outputs for the current cycle
aqed_pkg::qe_t     exp_q[$];
aqed_pkg::count_t  exp_occ;
int                exp_err;
int                init_left;
int                busy;
logic              op_deq;
aqed_pkg::qe_t     held_qe;
logic              exp_dv;
aqed_pkg::qe_t     exp_dv_qe;
logic [2:0]        pwr_pipe;

aqed_top i_dut (
     .clk                     (clk)
    ,.arst_n                  (arst_n)
    ,.enq                     (enq)
    ,.enq_qe                  (enq_qe)
    ,.deq                     (deq)
    ,.ready                   (ready)
    ,.deq_valid               (deq_valid)
    ,.deq_qe                  (deq_qe)
    ,.occupancy               (occupancy)
    ,.err_count               (err_count)
    ,.pwr_enable_b_in         (pwr_enable_b_in)
    ,.pwr_enable_b_out        (pwr_enable_b_out)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
        @(posedge clk);
        cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
    $display("tests failed");
    $fatal(1);
end

task automatic check_qe(input aqed_pkg::qe_t got, input aqed_pkg::qe_t exp, input string what);
    if (got !== exp) begin
        $display("Mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
        $display("tests failed");
        $fatal(1);
    end
endtask

task automatic check_count(input aqed_pkg::count_t got, input aqed_pkg::count_t exp,
                           input string what);
    if (got !== exp) begin
        $display("Mismatch at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
        $display("tests failed");
        $fatal(1);
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("Mismatch at %0d ns: %s got %b expected %b", $time, what, got, exp);
        $display("tests failed");
        $fatal(1);
    end
endtask

task automatic rand_qe(output aqed_pkg::qe_t v);
    logic [159:0] raw;
    raw = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
    v = raw[`AQED_DW-1:0];
endtask

// advances the reference model across one rising edge
task automatic model_step(input logic rdy);
    if (init_left > 0) init_left--;
    exp_dv = 1'b0;
    if (busy == 2) begin
        busy = 1;
        if (op_deq) begin
            exp_dv    = 1'b1;
            exp_dv_qe = exp_q[0];
        end
    end else if (busy == 1) begin
        busy = 0;
        if (op_deq) begin
            void'(exp_q.pop_front());
            exp_occ = exp_occ - 1'b1;
        end else begin
            exp_q.push_back(held_qe);
            exp_occ = exp_occ + 1'b1;
        end
    end
    if (enq || deq) begin
        if (rdy && enq && !deq && exp_occ < aqed_pkg::count_t'(`AQED_DEPTH)) begin
            busy    = 2;
            op_deq  = 1'b0;
            held_qe = enq_qe;
        end else if (rdy && deq && !enq && exp_occ != '0) begin
            busy   = 2;
            op_deq = 1'b1;
        end else if (exp_err < 255) begin
            exp_err++;
        end
    end
    pwr_pipe = {pwr_pipe[1:0], pwr_enable_b_in};
endtask

// compares at the falling edge and drives after the rising edge
task automatic tick();
    logic exp_ready;
    @(negedge clk);
    exp_ready = (init_left == 0) && (busy == 0);
    check_flag(ready, exp_ready, "ready");
    check_flag(deq_valid, exp_dv, "deq_valid");
    if (exp_dv) check_qe(deq_qe, exp_dv_qe, "deq_qe");
    check_count(occupancy, exp_occ, "occupancy");
    check_count(aqed_pkg::count_t'(err_count), aqed_pkg::count_t'(exp_err), "err_count");
    check_flag(pwr_enable_b_out, pwr_pipe[2], "pwr_enable_b_out");
    model_step(exp_ready);
    @(posedge clk);
    #5;
    enq = 1'b0;
    deq = 1'b0;
    if (($random(seed) & 32'hf) == 32'h0) pwr_enable_b_in = ~pwr_enable_b_in;
endtask

task automatic send_cmd(input logic do_enq, input logic do_deq);
    aqed_pkg::qe_t v;
    rand_qe(v);
    enq    = do_enq;
    deq    = do_deq;
    enq_qe = v;
    tick();
endtask

task automatic wait_ready();
    while (ready !== 1'b1) tick();
endtask

initial begin
    logic pick_deq;
    seed            = 32'h7497_f61a;
    arst_n          = 1'b0;
    enq             = 1'b0;
    deq             = 1'b0;
    enq_qe          = '0;
    pwr_enable_b_in = 1'b1;
    exp_occ         = '0;
    exp_err         = 0;
    busy            = 0;
    op_deq          = 1'b0;
    held_qe         = '0;
    exp_dv          = 1'b0;
    exp_dv_qe       = '0;
    pwr_pipe        = 3'b111;
    init_left       = `AQED_DEPTH;
    repeat (16) @(posedge clk);
    #5;
    arst_n = 1'b1;

    // freelist fill keeps ready low
    repeat (`AQED_DEPTH) tick();
    check_flag(ready, 1'b1, "ready after freelist init");
    check_count(occupancy, '0, "occupancy after init");
    check_count(aqed_pkg::count_t'(err_count), '0, "err_count after init");

    for (int i = 0; i < n_random; i++) begin
        pick_deq = (exp_occ != '0) && (($random(seed) & 32'h1) == 32'h1);
        send_cmd(!pick_deq, pick_deq);
        wait_ready();
    end
    check_count(aqed_pkg::count_t'(err_count), '0, "err_count after random traffic");

    while (occupancy != aqed_pkg::count_t'(`AQED_DEPTH)) begin
        send_cmd(1'b1, 1'b0);
        wait_ready();
    end

    // enqueue when full, both strobes, then an enqueue while busy
    send_cmd(1'b1, 1'b0);
    wait_ready();
    send_cmd(1'b1, 1'b1);
    wait_ready();
    send_cmd(1'b0, 1'b1);
    send_cmd(1'b1, 1'b0);
    wait_ready();

    while (occupancy != '0) begin
        send_cmd(1'b0, 1'b1);
        wait_ready();
    end

    // dequeue when empty
    send_cmd(1'b0, 1'b1);
    wait_ready();
    check_count(aqed_pkg::count_t'(err_count), aqed_pkg::count_t'(4),
                "err_count after illegal strobes");

    send_cmd(1'b1, 1'b0);
    wait_ready();
    send_cmd(1'b0, 1'b1);
    wait_ready();
    repeat (8) tick();
    check_count(occupancy, '0, "occupancy at end");

    $display("all tests passed");
    $finish;
end

endmodule

// ==== src.f ====
+incdir+.
aqed_pkg.sv
aqed_sram_pg.sv
aqed_mem.sv
aqed_freelist_ctl.sv
aqed_list_ctl.sv
aqed_top.sv
tb_aqed_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_aqed_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
